/* hw/spi_pkg.sv */
package spi_pkg;

  // Register bus address width, byte offsets inside the SPI block
  localparam int unsigned REG_ADDR_W = 5;

  // Register map
  localparam logic [REG_ADDR_W-1:0] REG_RX0_TX0 = 5'h00;
  localparam logic [REG_ADDR_W-1:0] REG_RX1_TX1 = 5'h04;
  localparam logic [REG_ADDR_W-1:0] REG_CTRL    = 5'h10;
  localparam logic [REG_ADDR_W-1:0] REG_DIVIDER = 5'h14;
  localparam logic [REG_ADDR_W-1:0] REG_SS      = 5'h18;

  // CTRL layout
  // char_len of 0 selects a full 64 bit transfer
  localparam int unsigned CTRL_CHAR_LEN_LSB = 0;
  localparam int unsigned CTRL_CHAR_LEN_W   = 7;
  localparam int unsigned CTRL_GO_BSY_BIT   = 8;
  localparam int unsigned CTRL_IE_BIT       = 12;

  // Divider register width, one sck half-period is divider + 1 clocks
  localparam int unsigned DIV_WIDTH = 16;

  // Number of slave select lines
  localparam int unsigned SS_WIDTH = 8;

  // Flash read opcode and the divider used for XIP fetches
  localparam logic [7:0]           XIP_READ_CMD = 8'h03;
  localparam logic [DIV_WIDTH-1:0] XIP_DIVIDER  = 16'd1;

  // Register bus opcode
  typedef enum logic {
    REG_READ  = 1'b0,
    REG_WRITE = 1'b1
  } reg_op_e;

  // Request, held stable by the requester until ready
  typedef struct packed {
    reg_op_e               op;
    logic [REG_ADDR_W-1:0] addr;
    logic [31:0]           wdata;
    logic [3:0]            be;
  } reg_req_t;

  // Response, valid in the ready cycle
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } reg_rsp_t;

endpackage

/* hw/apb_xip_pkg.sv */
package apb_xip_pkg;

  // Flash window, served by the XIP sequencer
  localparam logic [31:0] FLASH_BASE = 32'h3000_0000;
  localparam logic [31:0] FLASH_END  = 32'h3FFF_FFFF;

  // SPI master register window, passed straight through
  localparam logic [31:0] SPI_REG_BASE = 32'h1000_1000;
  localparam logic [31:0] SPI_REG_END  = 32'h1000_1FFF;

  // APB request from the system side
  typedef struct packed {
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
  } apb_req_t;

  // APB response, pready pulses once per access
  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
  } apb_rsp_t;

  // Bridge FSM
  // PASS forwards one register access, SEND_CMD to READ_RX form the XIP fetch
  typedef enum logic [3:0] {
    IDLE,
    PASS,
    SEND_CMD,
    SET_DIV,
    SET_SS,
    GO,
    POLL,
    CLEAR_SS,
    READ_RX,
    DONE
  } xip_state_e;

endpackage

/* hw/spi_shift_engine.sv */
module spi_shift_engine (
  input  logic        clock,
  input  logic        reset,
  input  logic        start_i,
  input  logic [63:0] tx_data_i,
  input  logic [6:0]  char_len_i,
  input  logic [15:0] divider_i,
  input  logic        spi_miso_i,
  output logic        busy_o,
  output logic        done_o,
  output logic [63:0] rx_data_o,
  output logic        spi_sck_o,
  output logic        spi_mosi_o
);

  logic [63:0] shift_q;
  // Counts down one sck half-period
  logic [15:0] cnt_q;
  // Bits still to go, 1 to 64
  logic [6:0]  bits_left_q;
  logic        busy_q;
  logic        done_q;
  logic        sck_q;
  // miso captured on the rising sck edge
  logic        miso_q;
  logic        launch;
  logic        half_end;
  logic [5:0]  msb_idx;

  assign launch   = start_i && !busy_q;
  assign half_end = busy_q && (cnt_q == '0);
  // char_len 0 wraps to index 63
  assign msb_idx  = 6'(char_len_i - 7'd1);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      sck_q       <= 1'b0;
      cnt_q       <= '0;
      bits_left_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (launch) begin
        busy_q      <= 1'b1;
        sck_q       <= 1'b0;
        cnt_q       <= divider_i;
        bits_left_q <= (char_len_i == '0) ? 7'd64 : char_len_i;
      end else if (busy_q) begin
        if (cnt_q != '0) begin
          cnt_q <= cnt_q - 16'd1;
        end else begin
          cnt_q <= divider_i;
          sck_q <= !sck_q;
          // Falling edge ends a bit
          if (sck_q) begin
            bits_left_q <= bits_left_q - 7'd1;
            if (bits_left_q == 7'd1) begin
              busy_q <= 1'b0;
              done_q <= 1'b1;
            end
          end
        end
      end
    end
  end

  // Data path
  // sample on rise, shift on fall so mosi moves with the falling edge
  always_ff @(posedge clock) begin
    if (launch) begin
      shift_q <= tx_data_i;
    end else if (half_end) begin
      if (!sck_q) begin
        miso_q <= spi_miso_i;
      end else begin
        shift_q <= {shift_q[62:0], miso_q};
      end
    end
  end

  assign busy_o     = busy_q;
  assign done_o     = done_q;
  assign rx_data_o  = shift_q;
  assign spi_sck_o  = sck_q;
  // Top bit of the active length goes out first
  assign spi_mosi_o = busy_q && shift_q[msb_idx];

  // Mode 0 idle level
  a_sck_idle: assert property (@(posedge clock) disable iff (reset)
    !busy_q |-> !sck_q);

endmodule

/* hw/spi_master_regs.sv */
module spi_master_regs (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         reg_valid_i,
  output logic                         reg_ready_o,
  input  spi_pkg::reg_req_t            reg_req_i,
  output spi_pkg::reg_rsp_t            reg_rsp_o,
  input  logic                         spi_miso_i,
  output logic                         spi_sck_o,
  output logic                         spi_mosi_o,
  output logic [spi_pkg::SS_WIDTH-1:0] spi_ss_o,
  output logic                         irq_o
);
  import spi_pkg::*;

  // TX and RX share one 64 bit data register
  logic [63:0]                data_q;
  logic [CTRL_CHAR_LEN_W-1:0] char_len_q;
  logic                       ie_q;
  logic [DIV_WIDTH-1:0]       div_q;
  logic [SS_WIDTH-1:0]        ss_q;
  logic                       irq_q;
  logic                       ready_q;
  logic                       start_q;
  reg_rsp_t                   rsp_q;
  logic                       eng_busy;
  logic                       eng_done;
  logic [63:0]                eng_rx;
  logic                       req_new;
  logic                       busy_w;
  logic                       is_write;
  logic                       addr_hit;
  logic                       locked;
  logic                       err_d;
  logic                       wr_ok;
  logic [31:0]                ctrl_rd;
  logic [31:0]                rdata_d;
  logic [31:0]                wr_word;

  function automatic logic [31:0] apply_be(input logic [31:0] cur,
                                           input logic [31:0] wdata,
                                           input logic [3:0]  be);
    logic [31:0] res;
    res = cur;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // New request only in the first valid cycle
  assign req_new  = reg_valid_i && !ready_q;
  // Done cycle counts as busy, RX is written back then
  assign busy_w   = eng_busy || eng_done || start_q;
  assign is_write = (reg_req_i.op == REG_WRITE);

  always_comb begin
    ctrl_rd = '0;
    ctrl_rd[CTRL_CHAR_LEN_LSB +: CTRL_CHAR_LEN_W] = char_len_q;
    ctrl_rd[CTRL_GO_BSY_BIT] = busy_w;
    ctrl_rd[CTRL_IE_BIT] = ie_q;
  end

  // Read mux, locked marks registers frozen during a transfer
  always_comb begin
    addr_hit = 1'b1;
    locked   = 1'b1;
    rdata_d  = '0;
    case (reg_req_i.addr)
      REG_RX0_TX0: rdata_d = data_q[31:0];
      REG_RX1_TX1: rdata_d = data_q[63:32];
      REG_CTRL:    rdata_d = ctrl_rd;
      REG_DIVIDER: rdata_d = 32'(div_q);
      REG_SS: begin
        rdata_d = 32'(ss_q);
        locked  = 1'b0;
      end
      default: addr_hit = 1'b0;
    endcase
  end

  // Merge write data into the current value
  assign wr_word = apply_be(rdata_d, reg_req_i.wdata, reg_req_i.be);
  assign err_d   = !addr_hit || (is_write && locked && busy_w);
  assign wr_ok   = req_new && is_write && !err_d;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ready_q    <= 1'b0;
      start_q    <= 1'b0;
      data_q     <= '0;
      char_len_q <= '0;
      ie_q       <= 1'b0;
      div_q      <= '0;
      ss_q       <= '0;
      irq_q      <= 1'b0;
    end else begin
      ready_q <= req_new;
      start_q <= 1'b0;
      if (wr_ok) begin
        case (reg_req_i.addr)
          REG_RX0_TX0: data_q[31:0] <= wr_word;
          REG_RX1_TX1: data_q[63:32] <= wr_word;
          REG_CTRL: begin
            char_len_q <= wr_word[CTRL_CHAR_LEN_LSB +: CTRL_CHAR_LEN_W];
            ie_q       <= wr_word[CTRL_IE_BIT];
            start_q    <= wr_word[CTRL_GO_BSY_BIT];
            irq_q      <= 1'b0;
          end
          REG_DIVIDER: div_q <= wr_word[DIV_WIDTH-1:0];
          REG_SS:      ss_q <= wr_word[SS_WIDTH-1:0];
          default: begin
          end
        endcase
      end
      // Received word replaces the data register
      if (eng_done) begin
        data_q <= eng_rx;
        if (ie_q) begin
          irq_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req_new) begin
      rsp_q <= '{rdata: rdata_d, err: err_d};
    end
  end

  spi_shift_engine spi_shift_engine_i (
    .clock      (clock),
    .reset      (reset),
    .start_i    (start_q),
    .tx_data_i  (data_q),
    .char_len_i (char_len_q),
    .divider_i  (div_q),
    .spi_miso_i (spi_miso_i),
    .busy_o     (eng_busy),
    .done_o     (eng_done),
    .rx_data_o  (eng_rx),
    .spi_sck_o  (spi_sck_o),
    .spi_mosi_o (spi_mosi_o)
  );

  assign reg_ready_o = ready_q;
  assign reg_rsp_o   = rsp_q;
  // Active-low selects
  assign spi_ss_o    = ~ss_q;
  assign irq_o       = irq_q;

  // Start only from idle, engine busy the next cycle
  a_start_idle: assert property (@(posedge clock) disable iff (reset)
    start_q |-> !eng_busy ##1 eng_busy);

endmodule

/* hw/apb_xip_bridge.sv */
module apb_xip_bridge (
  input  logic                  clock,
  input  logic                  reset,
  input  apb_xip_pkg::apb_req_t apb_req_i,
  output apb_xip_pkg::apb_rsp_t apb_rsp_o,
  output logic                  reg_valid_o,
  input  logic                  reg_ready_i,
  output spi_pkg::reg_req_t     reg_req_o,
  input  spi_pkg::reg_rsp_t     reg_rsp_i
);
  import apb_xip_pkg::*;
  import spi_pkg::*;

  xip_state_e  state_q;
  reg_req_t    req_q;
  logic        valid_q;
  logic        pready_q;
  logic        pslverr_q;
  logic [31:0] prdata_q;
  // Sticky error over all steps of one XIP fetch
  logic        xip_err_q;
  // SEND_CMD writes TX0 first, then TX1
  logic        cmd_step_q;
  logic        access;
  logic        in_flash;
  logic        in_regs;
  logic        handshake;
  logic [31:0] cmd_word;
  logic [31:0] go_word;

  function automatic reg_req_t wr_req(input logic [REG_ADDR_W-1:0] addr,
                                      input logic [31:0] data);
    return '{op: REG_WRITE, addr: addr, wdata: data, be: 4'hF};
  endfunction

  function automatic reg_req_t rd_req(input logic [REG_ADDR_W-1:0] addr);
    return '{op: REG_READ, addr: addr, wdata: '0, be: 4'h0};
  endfunction

  assign access    = apb_req_i.psel && apb_req_i.penable;
  assign in_flash  = (apb_req_i.paddr >= FLASH_BASE) && (apb_req_i.paddr <= FLASH_END);
  assign in_regs   = (apb_req_i.paddr >= SPI_REG_BASE) && (apb_req_i.paddr <= SPI_REG_END);
  assign handshake = valid_q && reg_ready_i;

  // Read command with 24 bit flash address, goes out first from TX1
  assign cmd_word = {XIP_READ_CMD, apb_req_i.paddr[23:0]};
  // GO_BSY with char_len 0, so all 64 bits shift
  assign go_word  = 32'(1) << CTRL_GO_BSY_BIT;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q    <= IDLE;
      valid_q    <= 1'b0;
      pready_q   <= 1'b0;
      pslverr_q  <= 1'b0;
      prdata_q   <= '0;
      xip_err_q  <= 1'b0;
      cmd_step_q <= 1'b0;
    end else begin
      // pready lasts one cycle
      pready_q <= 1'b0;
      if (handshake && reg_rsp_i.err) begin
        xip_err_q <= 1'b1;
      end
      case (state_q)
        IDLE: begin
          xip_err_q <= 1'b0;
          if (access) begin
            if (in_regs) begin
              state_q <= PASS;
              valid_q <= 1'b1;
              req_q   <= '{op: reg_op_e'(apb_req_i.pwrite),
                           addr: apb_req_i.paddr[REG_ADDR_W-1:0],
                           wdata: apb_req_i.pwdata,
                           be: apb_req_i.pstrb};
            end else if (in_flash && !apb_req_i.pwrite) begin
              // Clear TX0 so the tail of the frame shifts zeros
              state_q    <= SEND_CMD;
              valid_q    <= 1'b1;
              cmd_step_q <= 1'b0;
              req_q      <= wr_req(REG_RX0_TX0, '0);
            end else begin
              // Unmapped or flash write
              state_q   <= DONE;
              pready_q  <= 1'b1;
              pslverr_q <= 1'b1;
              prdata_q  <= '0;
            end
          end
        end
        SEND_CMD: begin
          if (handshake) begin
            if (!cmd_step_q) begin
              cmd_step_q <= 1'b1;
              req_q      <= wr_req(REG_RX1_TX1, cmd_word);
            end else begin
              state_q <= SET_DIV;
              req_q   <= wr_req(REG_DIVIDER, 32'(XIP_DIVIDER));
            end
          end
        end
        SET_DIV: begin
          if (handshake) begin
            state_q <= SET_SS;
            req_q   <= wr_req(REG_SS, 32'(1));
          end
        end
        SET_SS: begin
          if (handshake) begin
            state_q <= GO;
            req_q   <= wr_req(REG_CTRL, go_word);
          end
        end
        GO: begin
          if (handshake) begin
            state_q <= POLL;
            req_q   <= rd_req(REG_CTRL);
          end
        end
        POLL: begin
          // Same CTRL read again until the engine goes idle
          if (handshake && !reg_rsp_i.rdata[CTRL_GO_BSY_BIT]) begin
            state_q <= CLEAR_SS;
            req_q   <= wr_req(REG_SS, '0);
          end
        end
        CLEAR_SS: begin
          if (handshake) begin
            state_q <= READ_RX;
            req_q   <= rd_req(REG_RX0_TX0);
          end
        end
        PASS, READ_RX: begin
          if (handshake) begin
            state_q   <= DONE;
            valid_q   <= 1'b0;
            pready_q  <= 1'b1;
            prdata_q  <= reg_rsp_i.rdata;
            pslverr_q <= reg_rsp_i.err || xip_err_q;
          end
        end
        DONE: begin
          // Next access only once the master drops psel
          if (!apb_req_i.psel) begin
            state_q   <= IDLE;
            pslverr_q <= 1'b0;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign reg_valid_o = valid_q;
  assign reg_req_o   = req_q;
  assign apb_rsp_o   = '{pready: pready_q, prdata: prdata_q, pslverr: pslverr_q};

  // Request held until the register block takes it
  a_req_stable: assert property (@(posedge clock) disable iff (reset)
    reg_valid_o && !reg_ready_i |=> reg_valid_o && $stable(reg_req_o));

  // pready only answers an access phase
  a_pready_access: assert property (@(posedge clock) disable iff (reset)
    apb_rsp_o.pready |-> apb_req_i.psel && apb_req_i.penable);

endmodule

/* hw/spi_apb_top.sv */
module spi_apb_top (
  input  logic                         clock,
  input  logic                         reset,
  input  apb_xip_pkg::apb_req_t        apb_req_i,
  output apb_xip_pkg::apb_rsp_t        apb_rsp_o,
  output logic                         spi_sck_o,
  output logic [spi_pkg::SS_WIDTH-1:0] spi_ss_o,
  output logic                         spi_mosi_o,
  input  logic                         spi_miso_i,
  output logic                         spi_irq_o
);
  import spi_pkg::*;

  // Internal register bus
  logic     reg_valid;
  logic     reg_ready;
  reg_req_t reg_req;
  reg_rsp_t reg_rsp;

  // APB decode and XIP sequencing
  apb_xip_bridge apb_xip_bridge_i (
    .clock       (clock),
    .reset       (reset),
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .reg_valid_o (reg_valid),
    .reg_ready_i (reg_ready),
    .reg_req_o   (reg_req),
    .reg_rsp_i   (reg_rsp)
  );

  // SPI master registers with the shift engine inside
  spi_master_regs spi_master_regs_i (
    .clock       (clock),
    .reset       (reset),
    .reg_valid_i (reg_valid),
    .reg_ready_o (reg_ready),
    .reg_req_i   (reg_req),
    .reg_rsp_o   (reg_rsp),
    .spi_miso_i  (spi_miso_i),
    .spi_sck_o   (spi_sck_o),
    .spi_mosi_o  (spi_mosi_o),
    .spi_ss_o    (spi_ss_o),
    .irq_o       (spi_irq_o)
  );

endmodule

/* dv/spi_flash_model.sv */
module spi_flash_model (
  input  logic spi_sck_i,
  input  logic spi_ss_n_i,
  input  logic spi_mosi_i,
  output logic spi_miso_o
);

  // Only the plain read command is answered
  localparam logic [7:0] READ_CMD = 8'h03;
  // Data byte is the low address byte XOR this mask
  localparam logic [7:0] DATA_MASK = 8'hA5;
  // Command byte plus 24 address bits
  localparam int unsigned HEADER_BITS = 32;

  // Command and address, first bit ends up at the top
  logic [31:0] header_q;
  // Rising sck edges seen in this frame
  int unsigned bit_cnt;
  // Position inside the data stream
  int unsigned data_idx;
  logic [7:0]  data_byte;

  initial begin
    spi_miso_o = 1'b0;
    header_q   = '0;
    bit_cnt    = 0;
    data_idx   = 0;
    data_byte  = '0;
  end

  // Select going low opens a new frame
  always @(negedge spi_ss_n_i) begin
    bit_cnt  = 0;
    header_q = '0;
  end

  // Bus released while deselected
  always @(posedge spi_ss_n_i) begin
    spi_miso_o = 1'b0;
  end

  // Mode 0, mosi sampled on the rising sck edge
  always @(posedge spi_sck_i) begin
    if (spi_ss_n_i == 1'b0) begin
      if (bit_cnt < HEADER_BITS) begin
        header_q = {header_q[30:0], spi_mosi_i};
      end
      bit_cnt++;
    end
  end

  // Next data bit goes out after the falling edge
  // so it is stable at the following rising edge
  always @(negedge spi_sck_i) begin
    if (spi_ss_n_i == 1'b0 && bit_cnt >= HEADER_BITS && header_q[31:24] == READ_CMD) begin
      data_idx = bit_cnt - HEADER_BITS;
      // Byte k of the stream comes from address + k
      data_byte = 8'(header_q[7:0] + data_idx / 8) ^ DATA_MASK;
      // MSB first inside each byte
      spi_miso_o = data_byte[7 - data_idx % 8];
    end
  end

endmodule

/* dv/spi_apb_tb.sv */
module spi_apb_tb;
  import apb_xip_pkg::*;
  import spi_pkg::*;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned NUM_TESTS  = 6;
  localparam int unsigned XIP_READS  = 4;
  // Largest divider programmed by any test
  localparam int unsigned MAX_DIV    = 3;
  // Tests x 64 bits x 2 half-periods x (divider + 1) clocks, four times over
  localparam int unsigned WATCHDOG   = NUM_TESTS * 64 * 2 * (MAX_DIV + 1) * CLK_PERIOD * 4;

  logic                clock;
  logic                reset;
  apb_req_t            apb_req;
  apb_rsp_t            apb_rsp;
  logic                spi_sck;
  logic [SS_WIDTH-1:0] spi_ss;
  logic                spi_mosi;
  logic                spi_miso;
  logic                spi_irq;

  int unsigned err_count;
  int unsigned check_count;
  int unsigned test_count;
  int unsigned test_err_base;
  // Falling edges of slave select 0
  int unsigned ss_falls;
  // One pending value compare
  logic        chk_valid;
  logic [31:0] chk_got;
  logic [31:0] chk_exp;
  string       chk_name;
  // Windows where slave select may be low
  logic        xip_busy;
  logic        sw_ss;

  spi_apb_top spi_apb_top_i (
    .clock      (clock),
    .reset      (reset),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp),
    .spi_sck_o  (spi_sck),
    .spi_ss_o   (spi_ss),
    .spi_mosi_o (spi_mosi),
    .spi_miso_i (spi_miso),
    .spi_irq_o  (spi_irq)
  );

  // Flash sits on slave select 0
  spi_flash_model spi_flash_model_i (
    .spi_sck_i  (spi_sck),
    .spi_ss_n_i (spi_ss[0]),
    .spi_mosi_i (spi_mosi),
    .spi_miso_o (spi_miso)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  always @(negedge spi_ss[0]) begin
    if (!reset) begin
      ss_falls++;
    end
  end

  // Expected flash word, byte k from address + k in bits 31-8k down
  function automatic logic [31:0] flash_word(input logic [23:0] faddr);
    logic [31:0] word;
    logic [7:0]  low;
    word = '0;
    for (int k = 0; k < 4; k++) begin
      low = faddr[7:0] + 8'(k);
      word[31 - 8*k -: 8] = low ^ 8'hA5;
    end
    return word;
  endfunction

  // Hand one compare to the value assertion
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    @(posedge clock);
    chk_valid <= 1'b1;
    chk_name  <= name;
    chk_got   <= got;
    chk_exp   <= exp;
    check_count++;
    @(posedge clock);
    chk_valid <= 1'b0;
  endtask

  // Setup phase, access phase, then wait for pready
  task automatic apb_access(input logic [31:0] addr, input logic wr,
                            input logic [31:0] wdata, input logic [3:0] strb,
                            output logic [31:0] rdata, output logic err);
    @(posedge clock);
    apb_req <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: wr,
                 pwdata: wdata, pstrb: strb};
    @(posedge clock);
    apb_req.penable <= 1'b1;
    do begin
      @(posedge clock);
    end while (!apb_rsp.pready);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic reg_write(input logic [4:0] off, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] rd;
    logic        er;
    apb_access(SPI_REG_BASE + 32'(off), 1'b1, data, strb, rd, er);
    check_value("pslverr", 32'(er), 32'h0);
  endtask

  task automatic reg_read(input logic [4:0] off, output logic [31:0] data);
    logic er;
    apb_access(SPI_REG_BASE + 32'(off), 1'b0, '0, 4'h0, data, er);
    check_value("pslverr", 32'(er), 32'h0);
  endtask

  // One flash fetch through the window
  task automatic xip_read(input logic [31:0] addr);
    logic [31:0] rd;
    logic        er;
    int unsigned falls_before;
    falls_before = ss_falls;
    xip_busy <= 1'b1;
    apb_access(addr, 1'b0, '0, 4'h0, rd, er);
    xip_busy <= 1'b0;
    check_value("prdata", rd, flash_word(addr[23:0]));
    check_value("pslverr", 32'(er), 32'h0);
    // Exactly one select pulse per fetch
    check_value("ss_falls", ss_falls - falls_before, 32'h1);
  endtask

  // Software version of the XIP fetch, 64 bits with IE
  task automatic start_transfer(input logic [31:0] addr, input logic [15:0] div);
    sw_ss <= 1'b1;
    reg_write(REG_SS, 32'h1, 4'hF);
    reg_write(REG_DIVIDER, 32'(div), 4'hF);
    reg_write(REG_RX0_TX0, 32'h0, 4'hF);
    reg_write(REG_RX1_TX1, {XIP_READ_CMD, addr[23:0]}, 4'hF);
    reg_write(REG_CTRL, (32'h1 << CTRL_IE_BIT) | (32'h1 << CTRL_GO_BSY_BIT), 4'hF);
  endtask

  task automatic wait_idle();
    logic [31:0] ctrl;
    do begin
      reg_read(REG_CTRL, ctrl);
    end while (ctrl[CTRL_GO_BSY_BIT]);
  endtask

  // CTRL write drops irq, then release the slave
  task automatic close_transfer();
    reg_write(REG_CTRL, 32'h0, 4'hF);
    reg_write(REG_SS, 32'h0, 4'hF);
    sw_ss <= 1'b0;
  endtask

  // Extra edge lets the last assertion report first
  task automatic end_test(input string name);
    @(posedge clock);
    test_count++;
    if (err_count == test_err_base) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d errors", test_count, name, err_count - test_err_base);
    end
    test_err_base = err_count;
  endtask

  initial begin
    logic [31:0] addr;
    logic [31:0] rd;
    logic        er;
    logic [7:0]  ss_vals [4];
    ss_vals = '{8'h01, 8'h5A, 8'hC3, 8'h80};
    void'($urandom(41));
    reset         = 1'b1;
    apb_req       = '0;
    chk_valid     = 1'b0;
    chk_got       = '0;
    chk_exp       = '0;
    chk_name      = "";
    xip_busy      = 1'b0;
    sw_ss         = 1'b0;
    err_count     = 0;
    check_count   = 0;
    test_count    = 0;
    test_err_base = 0;
    ss_falls      = 0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);

    check_value("spi_ss", 32'(spi_ss), 32'hFF);
    check_value("spi_sck", 32'(spi_sck), 32'h0);
    check_value("spi_mosi", 32'(spi_mosi), 32'h0);
    check_value("spi_irq", 32'(spi_irq), 32'h0);
    check_value("pready", 32'(apb_rsp.pready), 32'h0);
    end_test("reset state");

    // Bytes 0 and 2 of TX0 change, byte 1 of DIVIDER changes
    reg_write(REG_RX0_TX0, 32'h1122_3344, 4'hF);
    reg_write(REG_RX0_TX0, 32'hAABB_CCDD, 4'b0101);
    reg_read(REG_RX0_TX0, rd);
    check_value("tx0", rd, 32'h11BB_33DD);
    reg_write(REG_DIVIDER, 32'h0000_5678, 4'hF);
    reg_write(REG_DIVIDER, 32'hFFFF_9A00, 4'b0010);
    reg_read(REG_DIVIDER, rd);
    check_value("divider", rd, 32'h0000_9A78);
    end_test("register access");

    for (int i = 0; i < XIP_READS; i++) begin
      addr = FLASH_BASE | ($urandom() & 32'h0FFF_FFFF);
      xip_read(addr);
    end
    end_test("xip reads");

    addr = FLASH_BASE | ($urandom() & 32'h00FF_FFFF);
    start_transfer(addr, 16'(MAX_DIV));
    wait_idle();
    check_value("spi_irq", 32'(spi_irq), 32'h1);
    reg_read(REG_RX0_TX0, rd);
    check_value("rx0", rd, flash_word(addr[23:0]));
    close_transfer();
    check_value("spi_irq", 32'(spi_irq), 32'h0);
    end_test("manual transfer");

    apb_access(32'h2000_0000, 1'b0, '0, 4'h0, rd, er);
    check_value("pslverr", 32'(er), 32'h1);
    apb_access(FLASH_BASE, 1'b1, 32'h1234_5678, 4'hF, rd, er);
    check_value("pslverr", 32'(er), 32'h1);
    addr = FLASH_BASE | ($urandom() & 32'h00FF_FFFF);
    start_transfer(addr, 16'(MAX_DIV));
    // Engine still shifting, the write must bounce
    apb_access(SPI_REG_BASE + 32'(REG_RX0_TX0), 1'b1, 32'hDEAD_BEEF, 4'hF, rd, er);
    check_value("pslverr", 32'(er), 32'h1);
    // TX0 keeps the zero loaded before the start
    reg_read(REG_RX0_TX0, rd);
    check_value("tx0", rd, 32'h0);
    wait_idle();
    reg_read(REG_RX0_TX0, rd);
    check_value("rx0", rd, flash_word(addr[23:0]));
    close_transfer();
    end_test("error paths");

    sw_ss <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      reg_write(REG_SS, 32'(ss_vals[i]), 4'hF);
      check_value("spi_ss", 32'(spi_ss), 32'(ss_vals[i] ^ 8'hFF));
    end
    reg_write(REG_SS, 32'h0, 4'hF);
    sw_ss <= 1'b0;
    end_test("slave selects");

    repeat (2) @(posedge clock);
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG);
    $display("Watchdog expired after %0d time units with tests still running", WATCHDOG);
    $display("Simulation failed");
    $finish;
  end

  a_value: assert property (@(posedge clock) chk_valid |-> chk_got == chk_exp)
    else begin
      err_count++;
      $display("FAIL %s: got 0x%h, expected 0x%h", chk_name, chk_got, chk_exp);
    end

  a_pready_pulse: assert property (@(posedge clock) disable iff (reset)
    apb_rsp.pready |=> !apb_rsp.pready)
    else begin
      err_count++;
      $display("pready stayed high for more than one cycle");
    end

  a_pready_phase: assert property (@(posedge clock) disable iff (reset)
    apb_rsp.pready |-> apb_req.psel && apb_req.penable)
    else begin
      err_count++;
      $display("pready came outside an access phase");
    end

  // Selects idle unless a fetch or a software transfer owns them
  a_ss_idle: assert property (@(posedge clock) disable iff (reset)
    !xip_busy && !sw_ss |-> spi_ss == '1)
    else begin
      err_count++;
      $display("a slave select was low with no transfer running");
    end

  a_ss_release: assert property (@(posedge clock) disable iff (reset)
    xip_busy && apb_rsp.pready |-> spi_ss[0])
    else begin
      err_count++;
      $display("slave select 0 still low when the flash read completed");
    end

  a_sck_select: assert property (@(posedge clock) disable iff (reset)
    spi_sck |-> !spi_ss[0])
    else begin
      err_count++;
      $display("sck was high while slave select 0 was released");
    end

endmodule

/* project.f */
hw/spi_pkg.sv
hw/apb_xip_pkg.sv
hw/spi_shift_engine.sv
hw/spi_master_regs.sv
hw/apb_xip_bridge.sv
hw/spi_apb_top.sv
dv/spi_flash_model.sv
dv/spi_apb_tb.sv

/* Bender.yml */
package:
  name: spi_apb_xip

sources:
  # Packages first, then RTL bottom-up
  - files:
      - hw/spi_pkg.sv
      - hw/apb_xip_pkg.sv
      - hw/spi_shift_engine.sv
      - hw/spi_master_regs.sv
      - hw/apb_xip_bridge.sv
      - hw/spi_apb_top.sv
  # Testbench with the flash model
  - target: test
    files:
      - dv/spi_flash_model.sv
      - dv/spi_apb_tb.sv
